// ==== src/kv_pkg.sv ====
// key vault shared definitions
// sizes, firmware register map, control bit positions, flush patterns
// and the typedefs for the widths that carry a meaning

package kv_pkg;

    // vault sizes
    localparam int KV_NUM_DWORDS = 4;
    localparam int KV_MAX_KEYS   = 8;
    localparam int KV_NUM_WRITE  = 2;
    localparam int KV_NUM_READ   = 2;
    localparam int KV_ENTRY_W    = $clog2(KV_MAX_KEYS);
    localparam int KV_OFFSET_W   = $clog2(KV_NUM_DWORDS);

    // entry mirrored on the signing key output
    localparam int KV_SIGNING_ENTRY = 7;

    // flush patterns, opposite phase of alternating bits
    localparam logic [31:0] KV_DEBUG_VALUE_0 = 32'hAAAA_AAAA;
    localparam logic [31:0] KV_DEBUG_VALUE_1 = 32'h5555_5555;

    // register map, key control registers sit at 0 .. NUM_KEYS-1
    localparam logic [3:0] KV_ADDR_CLEAR_SECRETS = 4'd8;

    // key control register fields
    localparam int KV_CTRL_LOCK_WR  = 0;
    localparam int KV_CTRL_LOCK_USE = 1;
    localparam int KV_CTRL_CLEAR    = 2;
    localparam int KV_CTRL_DEST_LSB = 4;
    localparam int KV_CTRL_LAST_LSB = 6;

    // clear secrets register fields
    localparam int KV_CS_WR_DEBUG  = 0;
    localparam int KV_CS_SEL_DEBUG = 1;

    typedef logic [31:0]              kv_dword_t;
    typedef logic [KV_ENTRY_W-1:0]    kv_entry_t;
    typedef logic [KV_OFFSET_W-1:0]   kv_offset_t;
    typedef logic [KV_NUM_READ-1:0]   kv_dest_t;
    typedef logic [3:0]               kv_reg_addr_t;

endpackage

// ==== src/kv_reg_decode.sv ====
// key vault firmware register port
// single cycle strobe access with a registered ack, sticky lock bits,
// registered clear pulses per entry, the debug flush strobe and readback

`timescale 1ns/1ps

module kv_reg_decode #(
    parameter int NUM_KEYS = 8
) (
    input  logic                                      clk,
    input  logic                                      rst_b,
    input  logic                                      reg_req_i,
    input  logic                                      reg_we_i,
    input  kv_pkg::kv_reg_addr_t                      reg_addr_i,
    input  kv_pkg::kv_dword_t                         reg_wdata_i,
    input  logic                                      debug_mode_i,
    input  logic                                      debug_unlock_i,
    input  kv_pkg::kv_dest_t   [NUM_KEYS-1:0]         dest_i,
    input  kv_pkg::kv_offset_t [NUM_KEYS-1:0]         last_dword_i,
    output logic                                      reg_ack_o,
    output logic                                      reg_err_o,
    output kv_pkg::kv_dword_t                         reg_rdata_o,
    output logic               [NUM_KEYS-1:0]         lock_wr_o,
    output logic               [NUM_KEYS-1:0]         lock_use_o,
    output logic               [NUM_KEYS-1:0]         clear_o,
    output logic                                      flush_o,
    output logic                                      flush_sel_o
);

    logic [NUM_KEYS-1:0] ctrl_wr;
    logic                cs_wr;
    logic                addr_ok;
    kv_pkg::kv_dword_t   rd_word;

    // address decode and readback word
    always_comb begin
        ctrl_wr = '0;
        addr_ok = 1'b0;
        rd_word = '0;
        for (int e = 0; e < NUM_KEYS; e++) begin
            if (reg_addr_i == e) begin
                addr_ok    = 1'b1;
                ctrl_wr[e] = reg_req_i & reg_we_i;
                rd_word[kv_pkg::KV_CTRL_LOCK_WR]  = lock_wr_o[e];
                rd_word[kv_pkg::KV_CTRL_LOCK_USE] = lock_use_o[e];
                rd_word[kv_pkg::KV_CTRL_DEST_LSB +: $bits(kv_pkg::kv_dest_t)] = dest_i[e];
                rd_word[kv_pkg::KV_CTRL_LAST_LSB +: $bits(kv_pkg::kv_offset_t)] =
                    last_dword_i[e];
            end
        end
        if (reg_addr_i == kv_pkg::KV_ADDR_CLEAR_SECRETS) begin
            addr_ok = 1'b1;
            rd_word[kv_pkg::KV_CS_SEL_DEBUG] = flush_sel_o;
        end
    end

    assign cs_wr = reg_req_i & reg_we_i & (reg_addr_i == kv_pkg::KV_ADDR_CLEAR_SECRETS);

    // response, one cycle after the request
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            reg_ack_o   <= 1'b0;
            reg_err_o   <= 1'b0;
            reg_rdata_o <= '0;
        end else begin
            reg_ack_o   <= reg_req_i;
            reg_err_o   <= reg_req_i & ~addr_ok;
            reg_rdata_o <= (reg_req_i & ~reg_we_i & addr_ok) ? rd_word : '0;
        end
    end

    // locks only ever set, reset is the sole way back
    // clear pulse is dropped when the entry holds either lock
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            lock_wr_o  <= '0;
            lock_use_o <= '0;
            clear_o    <= '0;
        end else begin
            for (int e = 0; e < NUM_KEYS; e++) begin
                clear_o[e] <= ctrl_wr[e] & reg_wdata_i[kv_pkg::KV_CTRL_CLEAR] &
                              ~lock_wr_o[e] & ~lock_use_o[e];
                if (ctrl_wr[e]) begin
                    lock_wr_o[e]  <= lock_wr_o[e] | reg_wdata_i[kv_pkg::KV_CTRL_LOCK_WR];
                    lock_use_o[e] <= lock_use_o[e] | reg_wdata_i[kv_pkg::KV_CTRL_LOCK_USE];
                end
            end
        end
    end

    // flush strobe lands one cycle after the request, so a write that sets
    // sel_debug_value and wr_debug_values together uses the new pattern
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            flush_o     <= 1'b0;
            flush_sel_o <= 1'b0;
        end else begin
            flush_o <= debug_unlock_i |
                       (cs_wr & debug_mode_i & reg_wdata_i[kv_pkg::KV_CS_WR_DEBUG]);
            if (cs_wr) begin
                flush_sel_o <= reg_wdata_i[kv_pkg::KV_CS_SEL_DEBUG];
            end
        end
    end

endmodule

// ==== src/kv_key_store.sv ====
// key vault storage
// holds the key dwords plus the dest mask and last dword of each entry,
// accepts client writes that pass lock, clear and conflict checks,
// wipes an entry on its clear pulse and fills every entry on flush

`timescale 1ns/1ps

module kv_key_store #(
    parameter int NUM_KEYS = 8
) (
    input  logic                                             clk,
    input  logic                                             rst_b,
    input  logic               [kv_pkg::KV_NUM_WRITE-1:0]    wr_en_i,
    input  kv_pkg::kv_entry_t  [kv_pkg::KV_NUM_WRITE-1:0]    wr_entry_i,
    input  kv_pkg::kv_offset_t [kv_pkg::KV_NUM_WRITE-1:0]    wr_offset_i,
    input  kv_pkg::kv_dword_t  [kv_pkg::KV_NUM_WRITE-1:0]    wr_data_i,
    input  kv_pkg::kv_dest_t   [kv_pkg::KV_NUM_WRITE-1:0]    wr_dest_i,
    input  logic               [NUM_KEYS-1:0]                lock_wr_i,
    input  logic               [NUM_KEYS-1:0]                lock_use_i,
    input  logic               [NUM_KEYS-1:0]                clear_i,
    input  logic                                             flush_i,
    input  logic                                             flush_sel_i,
    output logic               [kv_pkg::KV_NUM_WRITE-1:0]    wr_err_o,
    output kv_pkg::kv_dword_t  [NUM_KEYS-1:0][kv_pkg::KV_NUM_DWORDS-1:0] key_data_o,
    output kv_pkg::kv_dest_t   [NUM_KEYS-1:0]                dest_o,
    output kv_pkg::kv_offset_t [NUM_KEYS-1:0]                last_dword_o
);

    logic [kv_pkg::KV_NUM_WRITE-1:0] wr_blocked;
    logic [kv_pkg::KV_NUM_WRITE-1:0] wr_conflict;
    logic [kv_pkg::KV_NUM_WRITE-1:0] wr_ok;
    kv_pkg::kv_dword_t               flush_value;

    assign flush_value = flush_sel_i ? kv_pkg::KV_DEBUG_VALUE_1 : kv_pkg::KV_DEBUG_VALUE_0;

    // write qualification
    // an index past the last entry is blocked like a locked entry
    always_comb begin
        for (int c = 0; c < kv_pkg::KV_NUM_WRITE; c++) begin
            wr_blocked[c]  = 1'b1;
            wr_conflict[c] = 1'b0;
            for (int e = 0; e < NUM_KEYS; e++) begin
                if (wr_entry_i[c] == e) begin
                    wr_blocked[c] = lock_wr_i[e] | lock_use_i[e] | clear_i[e];
                end
            end
            // lower numbered client wins a shared entry
            for (int p = 0; p < c; p++) begin
                if (wr_en_i[p] && (wr_entry_i[p] == wr_entry_i[c])) begin
                    wr_conflict[c] = 1'b1;
                end
            end
            wr_ok[c]    = wr_en_i[c] & ~wr_blocked[c] & ~wr_conflict[c];
            wr_err_o[c] = wr_en_i[c] & (wr_blocked[c] | wr_conflict[c]);
        end
    end

    // key array and metadata
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            key_data_o   <= '0;
            dest_o       <= '0;
            last_dword_o <= '0;
        end else begin
            for (int e = 0; e < NUM_KEYS; e++) begin
                if (clear_i[e]) begin
                    key_data_o[e]   <= '0;
                    dest_o[e]       <= '0;
                    last_dword_o[e] <= '0;
                end else begin
                    // flush ignores locks and leaves metadata alone
                    if (flush_i) begin
                        key_data_o[e] <= {kv_pkg::KV_NUM_DWORDS{flush_value}};
                    end
                    for (int c = 0; c < kv_pkg::KV_NUM_WRITE; c++) begin
                        if (wr_ok[c] && (wr_entry_i[c] == e)) begin
                            if (!flush_i) begin
                                key_data_o[e][wr_offset_i[c]] <= wr_data_i[c];
                            end
                            dest_o[e]       <= wr_dest_i[c];
                            last_dword_o[e] <= wr_offset_i[c];
                        end
                    end
                end
            end
        end
    end

endmodule

// ==== src/kv_read_resp.sv ====
// key vault read response
// zero latency dword mux per read client, gated by lock_use and the
// client's dest valid bit, with the last dword flag

`timescale 1ns/1ps

module kv_read_resp #(
    parameter int NUM_KEYS = 8
) (
    input  kv_pkg::kv_entry_t  [kv_pkg::KV_NUM_READ-1:0]    rd_entry_i,
    input  kv_pkg::kv_offset_t [kv_pkg::KV_NUM_READ-1:0]    rd_offset_i,
    input  kv_pkg::kv_dword_t  [NUM_KEYS-1:0][kv_pkg::KV_NUM_DWORDS-1:0] key_data_i,
    input  kv_pkg::kv_dest_t   [NUM_KEYS-1:0]               dest_i,
    input  kv_pkg::kv_offset_t [NUM_KEYS-1:0]               last_dword_i,
    input  logic               [NUM_KEYS-1:0]               lock_use_i,
    output kv_pkg::kv_dword_t  [kv_pkg::KV_NUM_READ-1:0]    rd_data_o,
    output logic               [kv_pkg::KV_NUM_READ-1:0]    rd_last_o,
    output logic               [kv_pkg::KV_NUM_READ-1:0]    rd_err_o
);

    always_comb begin
        for (int c = 0; c < kv_pkg::KV_NUM_READ; c++) begin
            // default covers an entry index past the last entry
            rd_data_o[c] = '0;
            rd_last_o[c] = 1'b0;
            rd_err_o[c]  = 1'b1;
            for (int e = 0; e < NUM_KEYS; e++) begin
                if (rd_entry_i[c] == e) begin
                    rd_err_o[c]  = lock_use_i[e] | ~dest_i[e][c];
                    rd_last_o[c] = (rd_offset_i[c] == last_dword_i[e]);
                    if (!lock_use_i[e] && dest_i[e][c]) begin
                        rd_data_o[c] = key_data_i[e][rd_offset_i[c]];
                    end
                end
            end
        end
    end

endmodule

// ==== src/kv_top.sv ====
// key vault top level
// ties the firmware register decode, the key store and the read response
// together and mirrors the signing entry on signing_key_o

`timescale 1ns/1ps

module kv_top #(
    parameter int NUM_KEYS = 8
) (
    input  logic                                             clk,
    input  logic                                             rst_b,
    // firmware register port
    input  logic                                             reg_req_i,
    input  logic                                             reg_we_i,
    input  kv_pkg::kv_reg_addr_t                             reg_addr_i,
    input  kv_pkg::kv_dword_t                                reg_wdata_i,
    output logic                                             reg_ack_o,
    output logic                                             reg_err_o,
    output kv_pkg::kv_dword_t                                reg_rdata_o,
    input  logic                                             debug_mode_i,
    input  logic                                             debug_unlock_i,
    // key write clients
    input  logic               [kv_pkg::KV_NUM_WRITE-1:0]    wr_en_i,
    input  kv_pkg::kv_entry_t  [kv_pkg::KV_NUM_WRITE-1:0]    wr_entry_i,
    input  kv_pkg::kv_offset_t [kv_pkg::KV_NUM_WRITE-1:0]    wr_offset_i,
    input  kv_pkg::kv_dword_t  [kv_pkg::KV_NUM_WRITE-1:0]    wr_data_i,
    input  kv_pkg::kv_dest_t   [kv_pkg::KV_NUM_WRITE-1:0]    wr_dest_i,
    output logic               [kv_pkg::KV_NUM_WRITE-1:0]    wr_err_o,
    // key read clients
    input  kv_pkg::kv_entry_t  [kv_pkg::KV_NUM_READ-1:0]     rd_entry_i,
    input  kv_pkg::kv_offset_t [kv_pkg::KV_NUM_READ-1:0]     rd_offset_i,
    output kv_pkg::kv_dword_t  [kv_pkg::KV_NUM_READ-1:0]     rd_data_o,
    output logic               [kv_pkg::KV_NUM_READ-1:0]     rd_last_o,
    output logic               [kv_pkg::KV_NUM_READ-1:0]     rd_err_o,
    // signing key
    output kv_pkg::kv_dword_t  [kv_pkg::KV_NUM_DWORDS-1:0]   signing_key_o
);

    logic               [NUM_KEYS-1:0]                        lock_wr;
    logic               [NUM_KEYS-1:0]                        lock_use;
    logic               [NUM_KEYS-1:0]                        clear_req;
    logic                                                     flush;
    logic                                                     flush_sel;
    kv_pkg::kv_dword_t  [NUM_KEYS-1:0][kv_pkg::KV_NUM_DWORDS-1:0] key_data;
    kv_pkg::kv_dest_t   [NUM_KEYS-1:0]                        dest;
    kv_pkg::kv_offset_t [NUM_KEYS-1:0]                        last_dword;

    if (NUM_KEYS < 1 || NUM_KEYS > kv_pkg::KV_MAX_KEYS) begin : g_bad_num_keys
        $error("kv_top: NUM_KEYS out of range");
    end

    kv_reg_decode #(.NUM_KEYS(NUM_KEYS)) u_reg_decode (
        .clk           (clk),
        .rst_b         (rst_b),
        .reg_req_i     (reg_req_i),
        .reg_we_i      (reg_we_i),
        .reg_addr_i    (reg_addr_i),
        .reg_wdata_i   (reg_wdata_i),
        .debug_mode_i  (debug_mode_i),
        .debug_unlock_i(debug_unlock_i),
        .dest_i        (dest),
        .last_dword_i  (last_dword),
        .reg_ack_o     (reg_ack_o),
        .reg_err_o     (reg_err_o),
        .reg_rdata_o   (reg_rdata_o),
        .lock_wr_o     (lock_wr),
        .lock_use_o    (lock_use),
        .clear_o       (clear_req),
        .flush_o       (flush),
        .flush_sel_o   (flush_sel)
    );

    kv_key_store #(.NUM_KEYS(NUM_KEYS)) u_key_store (
        .clk         (clk),
        .rst_b       (rst_b),
        .wr_en_i     (wr_en_i),
        .wr_entry_i  (wr_entry_i),
        .wr_offset_i (wr_offset_i),
        .wr_data_i   (wr_data_i),
        .wr_dest_i   (wr_dest_i),
        .lock_wr_i   (lock_wr),
        .lock_use_i  (lock_use),
        .clear_i     (clear_req),
        .flush_i     (flush),
        .flush_sel_i (flush_sel),
        .wr_err_o    (wr_err_o),
        .key_data_o  (key_data),
        .dest_o      (dest),
        .last_dword_o(last_dword)
    );

    kv_read_resp #(.NUM_KEYS(NUM_KEYS)) u_read_resp (
        .rd_entry_i  (rd_entry_i),
        .rd_offset_i (rd_offset_i),
        .key_data_i  (key_data),
        .dest_i      (dest),
        .last_dword_i(last_dword),
        .lock_use_i  (lock_use),
        .rd_data_o   (rd_data_o),
        .rd_last_o   (rd_last_o),
        .rd_err_o    (rd_err_o)
    );

    // a vault smaller than the signing index has no signing key
    if (kv_pkg::KV_SIGNING_ENTRY < NUM_KEYS) begin : g_signing
        assign signing_key_o = key_data[kv_pkg::KV_SIGNING_ENTRY];
    end else begin : g_no_signing
        assign signing_key_o = '0;
    end

endmodule

// ==== testbench/kv_chk.sv ====
// key vault protocol checker
// concurrent assertions on the register port handshake and the
// write client error flags, bound into kv_top

`timescale 1ns/1ps

module kv_chk (
    input logic                            clk,
    input logic                            rst_b,
    input logic                            reg_req_i,
    input logic                            reg_ack_o,
    input logic                            reg_err_o,
    input logic [kv_pkg::KV_NUM_WRITE-1:0] wr_en_i,
    input logic [kv_pkg::KV_NUM_WRITE-1:0] wr_err_o
);

    int fail_count = 0;

    // ack follows every request by exactly one cycle
    ack_follows_req: assert property (@(posedge clk) disable iff (!rst_b)
        reg_ack_o == $past(reg_req_i))
        else begin
            fail_count++;
            $error("reg_ack_o does not match the request one cycle earlier");
        end

    // a write error only answers an active write strobe
    wr_err_needs_en: assert property (@(posedge clk) disable iff (!rst_b)
        (wr_err_o & ~wr_en_i) == '0)
        else begin
            fail_count++;
            $error("wr_err_o set on a client without wr_en_i");
        end

    reg_err_with_ack: assert property (@(posedge clk) disable iff (!rst_b)
        reg_err_o |-> reg_ack_o)
        else begin
            fail_count++;
            $error("reg_err_o set without reg_ack_o");
        end

endmodule

bind kv_top kv_chk u_chk (.*);

// ==== testbench/kv_tb.sv ====
// key vault testbench
// runs the operation list from the patterns file against kv_top and
// checks register, key read and signing key responses

`timescale 1ns/1ps

module kv_tb;

    localparam int NUM_KEYS = 8;
    localparam int MAX_OPS  = 64;

    logic                                           clk;
    logic                                           rst_b;
    logic                                           reg_req_i;
    logic                                           reg_we_i;
    kv_pkg::kv_reg_addr_t                           reg_addr_i;
    kv_pkg::kv_dword_t                              reg_wdata_i;
    logic                                           reg_ack_o;
    logic                                           reg_err_o;
    kv_pkg::kv_dword_t                              reg_rdata_o;
    logic                                           debug_mode_i;
    logic                                           debug_unlock_i;
    logic               [kv_pkg::KV_NUM_WRITE-1:0]  wr_en_i;
    kv_pkg::kv_entry_t  [kv_pkg::KV_NUM_WRITE-1:0]  wr_entry_i;
    kv_pkg::kv_offset_t [kv_pkg::KV_NUM_WRITE-1:0]  wr_offset_i;
    kv_pkg::kv_dword_t  [kv_pkg::KV_NUM_WRITE-1:0]  wr_data_i;
    kv_pkg::kv_dest_t   [kv_pkg::KV_NUM_WRITE-1:0]  wr_dest_i;
    logic               [kv_pkg::KV_NUM_WRITE-1:0]  wr_err_o;
    kv_pkg::kv_entry_t  [kv_pkg::KV_NUM_READ-1:0]   rd_entry_i;
    kv_pkg::kv_offset_t [kv_pkg::KV_NUM_READ-1:0]   rd_offset_i;
    kv_pkg::kv_dword_t  [kv_pkg::KV_NUM_READ-1:0]   rd_data_o;
    logic               [kv_pkg::KV_NUM_READ-1:0]   rd_last_o;
    logic               [kv_pkg::KV_NUM_READ-1:0]   rd_err_o;
    kv_pkg::kv_dword_t  [kv_pkg::KV_NUM_DWORDS-1:0] signing_key_o;

    logic [31:0]       pat [MAX_OPS][7];
    kv_pkg::kv_dword_t model_key [NUM_KEYS][kv_pkg::KV_NUM_DWORDS];
    int                n_ops;
    int                cycles = 0;
    int                limit  = 1000;
    integer            seed;

    kv_top #(.NUM_KEYS(NUM_KEYS)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // cycle limit guards against a stuck run
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("** FAIL **");
            $fatal(1, "stopped by the cycle limit");
        end
    end

    task automatic report_mismatch(input string msg);
        $display("[ERROR] time %0t: %s", $time, msg);
        $display("** FAIL **");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic check_dword(input kv_pkg::kv_dword_t got, input kv_pkg::kv_dword_t exp,
                               input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s: got %08h, expected %08h", what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s: got %b, expected %b", what, got, exp));
        end
    endtask

    task automatic check_offset(input kv_pkg::kv_offset_t got, input kv_pkg::kv_offset_t exp,
                                input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s: got %0d, expected %0d", what, got, exp));
        end
    endtask

    // strobes drop back to idle at every edge unless an operation drives them
    task automatic go_idle();
        reg_req_i      <= 1'b0;
        reg_we_i       <= 1'b0;
        wr_en_i        <= '0;
        debug_mode_i   <= 1'b0;
        debug_unlock_i <= 1'b0;
    endtask

    task automatic drive_write(input int c, input kv_pkg::kv_entry_t entry,
                               input kv_pkg::kv_offset_t off, input kv_pkg::kv_dest_t dest,
                               input kv_pkg::kv_dword_t data);
        wr_en_i[c]     <= 1'b1;
        wr_entry_i[c]  <= entry;
        wr_offset_i[c] <= off;
        wr_dest_i[c]   <= dest;
        wr_data_i[c]   <= data;
    endtask

    // request at one edge, ack sampled in the following cycle
    task automatic reg_access(input logic we, input kv_pkg::kv_reg_addr_t addr,
                              input kv_pkg::kv_dword_t data, input logic dbg);
        @(posedge clk);
        go_idle();
        reg_req_i    <= 1'b1;
        reg_we_i     <= we;
        reg_addr_i   <= addr;
        reg_wdata_i  <= data;
        debug_mode_i <= dbg;
        @(posedge clk);
        go_idle();
        @(negedge clk);
        check_flag(reg_ack_o, 1'b1, "register ack");
    endtask

    task automatic check_reg_resp(input kv_pkg::kv_dword_t exp_data, input logic exp_err);
        check_flag(reg_err_o, exp_err, "register error");
        check_offset(reg_rdata_o[kv_pkg::KV_CTRL_LAST_LSB +: $bits(kv_pkg::kv_offset_t)],
                     exp_data[kv_pkg::KV_CTRL_LAST_LSB +: $bits(kv_pkg::kv_offset_t)],
                     "readback last_dword");
        check_dword(reg_rdata_o, exp_data, "register read data");
    endtask

    task automatic key_read(input int c, input kv_pkg::kv_entry_t entry,
                            input kv_pkg::kv_offset_t off, input logic exp_err,
                            input logic exp_last, input kv_pkg::kv_dword_t exp_data);
        @(posedge clk);
        go_idle();
        rd_entry_i[c]  <= entry;
        rd_offset_i[c] <= off;
        @(negedge clk);
        check_flag(rd_err_o[c], exp_err, "read error");
        check_flag(rd_last_o[c], exp_last, "read last");
        check_dword(rd_data_o[c], exp_data, "read data");
    endtask

    task automatic run_op(input int i);
        logic [31:0]        f [7];
        int                 c;
        kv_pkg::kv_entry_t  entry;
        kv_pkg::kv_offset_t off;
        kv_pkg::kv_dword_t  data;
        for (int k = 0; k < 7; k++) begin
            f[k] = pat[i][k];
        end
        c     = int'(f[1]);
        entry = kv_pkg::kv_entry_t'(f[2]);
        off   = kv_pkg::kv_offset_t'(f[3]);
        case (f[0])
            32'h1: begin
                reg_access(1'b1, kv_pkg::kv_reg_addr_t'(f[1]), f[2], 1'b0);
                check_reg_resp('0, f[3][0]);
            end
            32'h2: begin
                reg_access(1'b0, kv_pkg::kv_reg_addr_t'(f[1]), '0, 1'b0);
                check_reg_resp(f[2], f[3][0]);
            end
            32'h3, 32'h4: begin
                data = (f[0] == 32'h4) ? $random(seed) : f[5];
                @(posedge clk);
                go_idle();
                drive_write(c, entry, off, kv_pkg::kv_dest_t'(f[4]), data);
                @(negedge clk);
                check_flag(wr_err_o[c], f[6][0], "write error");
                if (!f[6][0]) begin
                    model_key[entry][off] = data;
                end
            end
            32'h5: key_read(c, entry, off, f[4][0], f[5][0], f[4][0] ? '0 : model_key[entry][off]);
            32'h6: key_read(c, entry, off, f[4][0], f[5][0], f[6]);
            32'h7: begin
                data = '0;
                data[kv_pkg::KV_CS_SEL_DEBUG] = f[1][0];
                data[kv_pkg::KV_CS_WR_DEBUG]  = 1'b1;
                reg_access(1'b1, kv_pkg::KV_ADDR_CLEAR_SECRETS, data, 1'b1);
                check_reg_resp('0, 1'b0);
            end
            32'h8: begin
                @(posedge clk);
                go_idle();
                @(negedge clk);
                for (int d = 0; d < kv_pkg::KV_NUM_DWORDS; d++) begin
                    check_dword(signing_key_o[d], f[1], $sformatf("signing key dword %0d", d));
                end
            end
            32'h9: begin
                entry = kv_pkg::kv_entry_t'(f[1]);
                off   = kv_pkg::kv_offset_t'(f[2]);
                @(posedge clk);
                go_idle();
                drive_write(0, entry, off, kv_pkg::kv_dest_t'(f[3]), f[4]);
                drive_write(1, entry, off, kv_pkg::kv_dest_t'(f[3]), f[5]);
                @(negedge clk);
                check_flag(wr_err_o[0], 1'b0, "client 0 write error");
                check_flag(wr_err_o[1], f[6][0], "client 1 write error");
                model_key[entry][off] = f[4];
            end
            32'ha: begin
                // clear request, then a key write while the clear pulse is high
                entry = kv_pkg::kv_entry_t'(f[1]);
                c     = int'(f[2]);
                @(posedge clk);
                go_idle();
                reg_req_i   <= 1'b1;
                reg_we_i    <= 1'b1;
                reg_addr_i  <= kv_pkg::kv_reg_addr_t'(entry);
                reg_wdata_i <= 32'h1 << kv_pkg::KV_CTRL_CLEAR;
                @(posedge clk);
                go_idle();
                drive_write(c, entry, off, 2'b01, f[4]);
                @(negedge clk);
                check_flag(reg_ack_o, 1'b1, "register ack");
                check_flag(reg_err_o, 1'b0, "register error");
                check_flag(wr_err_o[c], 1'b1, "write error during clear");
                for (int d = 0; d < kv_pkg::KV_NUM_DWORDS; d++) begin
                    model_key[entry][d] = '0;
                end
            end
            default: begin
                $display("unknown operation %0h on pattern line %0d", f[0], i);
                $display("** FAIL **");
                $fatal(1, "bad pattern file");
            end
        endcase
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        logic [31:0] f [7];
        seed           = 32'hc09305b9;
        rst_b          = 1'b0;
        reg_req_i      = 1'b0;
        reg_we_i       = 1'b0;
        reg_addr_i     = '0;
        reg_wdata_i    = '0;
        debug_mode_i   = 1'b0;
        debug_unlock_i = 1'b0;
        wr_en_i        = '0;
        wr_entry_i     = '0;
        wr_offset_i    = '0;
        wr_data_i      = '0;
        wr_dest_i      = '0;
        rd_entry_i     = '0;
        rd_offset_i    = '0;
        for (int e = 0; e < NUM_KEYS; e++) begin
            for (int d = 0; d < kv_pkg::KV_NUM_DWORDS; d++) begin
                model_key[e][d] = '0;
            end
        end
        fd = $fopen("testbench/kv_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/kv_patterns.txt");
            $display("** FAIL **");
            $fatal(1, "no pattern file");
        end
        n_ops = 0;
        while ($fgets(line, fd) != 0) begin
            if (line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
                if (n == 7 && n_ops < MAX_OPS) begin
                    for (int k = 0; k < 7; k++) begin
                        pat[n_ops][k] = f[k];
                    end
                    n_ops++;
                end
            end
        end
        $fclose(fd);
        limit = n_ops * 4 + 50;
        repeat (8) @(posedge clk);
        rst_b <= 1'b1;
        for (int i = 0; i < n_ops; i++) begin
            run_op(i);
        end
        @(posedge clk);
        @(negedge clk);
        // protocol assertions of the bound checker count into fail_count
        if (uut.u_chk.fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== build.f ====
src/kv_pkg.sv
src/kv_reg_decode.sv
src/kv_key_store.sv
src/kv_read_resp.sv
src/kv_top.sv
testbench/kv_chk.sv
testbench/kv_tb.sv

// ==== testbench/kv_patterns.txt ====
# columns: op a b c d e f, all hex. ops: 1 reg wr, 2 reg rd, 3 key wr, 4 key wr random,
# 5 key rd vs model, 6 key rd vs value, 7 debug flush, 8 signing key, 9 dual wr, a clear+wr
4 0 2 0 1 0 0
4 0 2 1 1 0 0
4 0 2 2 1 0 0
4 0 2 3 1 0 0
5 0 2 0 0 0 0
5 0 2 1 0 0 0
5 0 2 2 0 0 0
5 0 2 3 0 1 0
5 1 2 3 1 1 0
2 2 d0 0 0 0 0
3 0 3 1 2 12345678 0
1 3 1 0 0 0 0
3 0 3 1 2 deadbeef 1
6 1 3 1 0 1 12345678
2 3 61 0 0 0 0
1 3 0 0 0 0 0
2 3 61 0 0 0 0
4 1 4 0 3 0 0
1 4 2 0 0 0 0
5 0 4 0 1 1 0
1 4 4 0 0 0 0
2 4 32 0 0 0 0
4 0 5 2 1 0 0
a 5 1 2 abcd0123 0 0
6 0 5 2 1 0 0
2 5 0 0 0 0 0
2 9 0 1 0 0 0
9 6 0 3 cafef00d 0badf00d 1
6 1 6 0 0 1 cafef00d
1 8 1 0 0 0 0
5 0 2 0 0 0 0
7 1 0 0 0 0 0
6 1 3 1 0 1 55555555
6 0 2 3 0 1 55555555
8 55555555 0 0 0 0 0
